// File: logic/display_pkg.sv
package display_pkg;

    //--------------------------------------------------
    // Board geometry
    //--------------------------------------------------

    // Digits of the multiplexed display
    localparam int w_digit = 8;

    // LEDs next to the display
    localparam int w_led = 8;

    //--------------------------------------------------
    // Scan timing
    //--------------------------------------------------

    // Clock cycles each digit stays selected.
    // Real hardware needs a few hundred microseconds per digit
    localparam int scan_period = 4;

    //--------------------------------------------------
    // Segment patterns
    //--------------------------------------------------

    // Bit 7 is segment a, bit 0 is the dot (h)
    localparam logic [7:0] segment_codes [0:15] = '{
        8'b1111_1100,  // 0
        8'b0110_0000,  // 1
        8'b1101_1010,  // 2
        8'b1111_0010,  // 3
        8'b0110_0110,  // 4
        8'b1011_0110,  // 5
        8'b1011_1110,  // 6
        8'b1110_0000,  // 7
        8'b1111_1110,  // 8
        8'b1111_0110,  // 9
        8'b1110_1110,  // A
        8'b0011_1110,  // b
        8'b1001_1100,  // C
        8'b0111_1010,  // d
        8'b1001_1110,  // E
        8'b1000_1110   // F
    };

    // All segments dark
    localparam logic [7:0] sign_empty_entry = 8'b0000_0000;

endpackage

// File: logic/lab_pkg.sv
package lab_pkg;

    //--------------------------------------------------
    // Data path geometry
    //--------------------------------------------------

    // Payload bits carried by each register stage
    localparam int width = 4;

    // One register stage per display digit
    localparam int depth = display_pkg::w_digit;

    // Keys on the board
    localparam int w_key = 4;

    //--------------------------------------------------
    // Step cadence
    //--------------------------------------------------

    // Clock cycles between two consecutive steps.
    // Kept short for simulation, a board build makes it much larger
    localparam int step_period = 4;

    //--------------------------------------------------
    // Pattern table
    //--------------------------------------------------

    // Entry 0 is the first value that enters the register
    localparam logic [width - 1:0] pattern_table [0:15] = '{
        4'h2, 4'h6, 4'hd, 4'hb,
        4'h7, 4'he, 4'hc, 4'h4,
        4'h1, 4'h0, 4'h9, 4'ha,
        4'hf, 4'h5, 4'h8, 4'h3
    };

endpackage

// File: logic/pattern_source.sv
`timescale 1ns/1ps

module pattern_source
(
    input  logic                        clk,
    input  logic                        reset,

    input  logic [lab_pkg::w_key - 1:0] key,

    output logic                        step,
    output logic                        in_valid,
    output logic [lab_pkg::width - 1:0] in_data
);

    //--------------------------------------------------
    // Step strobe
    //--------------------------------------------------

    // One spare bit so that a period of 1 still gets a counter
    localparam int w_step_cnt = $clog2(lab_pkg::step_period + 1);

    localparam logic [w_step_cnt - 1:0] step_last
        = w_step_cnt'(lab_pkg::step_period - 1);

    logic [w_step_cnt - 1:0] step_cnt;

    always_ff @ (posedge clk)
    begin
        if (reset)
            step_cnt <= '0;
        else if (step)
            step_cnt <= '0;
        else
            step_cnt <= step_cnt + 1'b1;
    end

    // High in the last cycle of every period
    assign step = (step_cnt == step_last);

    //--------------------------------------------------
    // Key detection
    //--------------------------------------------------

    // Any key counts, sampled only in the step cycle
    assign in_valid = step & (| key);

    //--------------------------------------------------
    // Table index
    //--------------------------------------------------

    // Sixteen entries, so the counter wraps by itself
    logic [3:0] index;

    always_ff @ (posedge clk)
    begin
        if (reset)
            index <= '0;
        else if (in_valid)
            index <= index + 1'b1;
    end

    //--------------------------------------------------
    // Table lookup
    //--------------------------------------------------

    // A bubble step leaves the index alone, so the
    // next held step repeats nothing and skips nothing
    assign in_data = lab_pkg::pattern_table [index];

endmodule

// File: logic/shift_register_with_valid_and_debug.sv
`timescale 1ns/1ps

module shift_register_with_valid_and_debug
#(
    parameter int width = 4,
    parameter int depth = 8
)
(
    input  logic                              clk,
    input  logic                              reset,

    input  logic                              shift,
    input  logic                              in_valid,
    input  logic [width - 1:0]                in_data,

    output logic [depth - 1:0]                debug_valid,
    output logic [depth - 1:0][width - 1:0]   debug_data
);

    //--------------------------------------------------
    // Valid chain
    //--------------------------------------------------

    // Stage 0 is the newest entry
    always_ff @ (posedge clk)
    begin
        if (reset)
        begin
            debug_valid <= '0;
        end
        else if (shift)
        begin
            for (int i = depth - 1; i > 0; i--)
                debug_valid [i] <= debug_valid [i - 1];

            debug_valid [0] <= in_valid;
        end
    end

    //--------------------------------------------------
    // Data chain
    //--------------------------------------------------

    // Moves in lockstep with the valid chain.
    // A bubble still carries whatever data came with it
    always_ff @ (posedge clk)
    begin
        if (shift)
        begin
            for (int i = depth - 1; i > 0; i--)
                debug_data [i] <= debug_data [i - 1];

            debug_data [0] <= in_data;
        end
    end

endmodule

// File: logic/seven_segment_display.sv
`timescale 1ns/1ps

module seven_segment_display
(
    input  logic                                 clk,
    input  logic                                 reset,

    input  logic [display_pkg::w_digit - 1:0][3:0] number,
    input  logic [display_pkg::w_digit - 1:0]      number_valid,

    output logic [7:0]                           abcdefgh,
    output logic [display_pkg::w_digit - 1:0]    digit
);

    //--------------------------------------------------
    // Local sizes
    //--------------------------------------------------

    localparam int w_index    = $clog2(display_pkg::w_digit);
    localparam int w_scan_cnt = $clog2(display_pkg::scan_period + 1);

    localparam logic [w_scan_cnt - 1:0] scan_last
        = w_scan_cnt'(display_pkg::scan_period - 1);

    localparam logic [w_index - 1:0] index_last
        = w_index'(display_pkg::w_digit - 1);

    //--------------------------------------------------
    // Scan timer
    //--------------------------------------------------

    logic [w_scan_cnt - 1:0] scan_timer;
    logic                    scan_tick;

    always_ff @ (posedge clk)
    begin
        if (reset)
            scan_timer <= '0;
        else if (scan_tick)
            scan_timer <= '0;
        else
            scan_timer <= scan_timer + 1'b1;
    end

    assign scan_tick = (scan_timer == scan_last);

    //--------------------------------------------------
    // Scan index
    //--------------------------------------------------

    // Walks 0, 1, ... w_digit - 1 and back to 0
    logic [w_index - 1:0] scan_index;

    always_ff @ (posedge clk)
    begin
        if (reset)
            scan_index <= '0;
        else if (scan_tick)
        begin
            if (scan_index == index_last)
                scan_index <= '0;
            else
                scan_index <= scan_index + 1'b1;
        end
    end

    //--------------------------------------------------
    // Digit select and segment decode
    //--------------------------------------------------

    // Both registered on the same edge from the same index,
    // so a segment pattern never shows up on a neighbour digit
    logic [7:0] segment_code;

    always_ff @ (posedge clk)
    begin
        if (reset)
            digit <= display_pkg::w_digit'(1);
        else
            digit <= display_pkg::w_digit'(1) << scan_index;
    end

    always_ff @ (posedge clk)
    begin
        segment_code <= display_pkg::segment_codes [number [scan_index]];
    end

    //--------------------------------------------------
    // Blanking
    //--------------------------------------------------

    // Uses the current valid bits, so a digit goes dark
    // in the very cycle its entry leaves
    always_comb
    begin
        if ((digit & number_valid) == '0)
            abcdefgh = display_pkg::sign_empty_entry;
        else
            abcdefgh = segment_code;
    end

endmodule

// File: logic/lab_top.sv
`timescale 1ns/1ps

module lab_top
(
    input  logic                             clk,
    input  logic                             reset,

    input  logic [3:0]                       key,

    output logic [display_pkg::w_led   - 1:0] led,

    output logic [7:0]                       abcdefgh,
    output logic [display_pkg::w_digit - 1:0] digit
);

    //--------------------------------------------------
    // Pattern source
    //--------------------------------------------------

    logic                        step;
    logic                        in_valid;
    logic [lab_pkg::width - 1:0] in_data;

    pattern_source i_source
    (
        .clk      (clk),
        .reset    (reset),
        .key      (key),
        .step     (step),
        .in_valid (in_valid),
        .in_data  (in_data)
    );

    //--------------------------------------------------
    // Shift register
    //--------------------------------------------------

    logic [lab_pkg::depth - 1:0]                        debug_valid;
    logic [lab_pkg::depth - 1:0][lab_pkg::width - 1:0]  debug_data;

    shift_register_with_valid_and_debug
    #(
        .width (lab_pkg::width),
        .depth (lab_pkg::depth)
    )
    i_fifo
    (
        .clk         (clk),
        .reset       (reset),
        .shift       (step),
        .in_valid    (in_valid),
        .in_data     (in_data),
        .debug_valid (debug_valid),
        .debug_data  (debug_data)
    );

    //--------------------------------------------------
    // Mirroring
    //--------------------------------------------------

    // Stage 0 lands on the leftmost digit
    logic [lab_pkg::depth - 1:0]                        debug_valid_mirrored;
    logic [lab_pkg::depth - 1:0][lab_pkg::width - 1:0]  debug_data_mirrored;

    for (genvar i = 0; i < lab_pkg::depth; i++)
    begin : gen_mirror
        assign debug_valid_mirrored [i] = debug_valid [lab_pkg::depth - 1 - i];
        assign debug_data_mirrored  [i] = debug_data  [lab_pkg::depth - 1 - i];
    end

    assign led = debug_valid_mirrored;

    //--------------------------------------------------
    // Display
    //--------------------------------------------------

    seven_segment_display i_display
    (
        .clk          (clk),
        .reset        (reset),
        .number       (debug_data_mirrored),
        .number_valid (debug_valid_mirrored),
        .abcdefgh     (abcdefgh),
        .digit        (digit)
    );

endmodule

// File: verification/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen
#(
    parameter int period_ns      = 100,
    parameter int reset_cycles   = 4,
    parameter int drive_delay_ns = 10
)
(
    input  logic restart,
    output logic clk,
    output logic reset
);

    initial
    begin
        clk = 1'b0;
        forever
            #(period_ns / 2) clk = ~clk;
    end

    // Power-on reset, then one more reset for every restart request
    initial
    begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #(drive_delay_ns) reset = 1'b0;

        forever
        begin
            @(posedge restart);
            reset = 1'b1;
            repeat (reset_cycles) @(posedge clk);
            #(drive_delay_ns) reset = 1'b0;
        end
    end

endmodule

// File: verification/lab_top_assertions.sv
`timescale 1ns/1ps

module lab_top_assertions
(
    input logic                              clk,
    input logic                              reset,

    input logic                              step,
    input logic [display_pkg::w_led   - 1:0] led,

    input logic [7:0]                        abcdefgh,
    input logic [display_pkg::w_digit - 1:0] digit
);

    //--------------------------------------------------
    // Display scan
    //--------------------------------------------------

    // Exactly one digit driven at a time
    digit_one_hot : assert property
    (
        @(posedge clk) disable iff (reset) $onehot(digit)
    )
    else
        $error("digit select %b is not one-hot", digit);

    // A digit without a valid entry stays dark
    empty_digit_blank : assert property
    (
        @(posedge clk) disable iff (reset)
        ((digit & led) == '0) |-> (abcdefgh == display_pkg::sign_empty_entry)
    )
    else
        $error("digit %b lit with %h while its entry is empty", digit, abcdefgh);

    //--------------------------------------------------
    // Shift cadence
    //--------------------------------------------------

    // LEDs move only with the shift register
    led_moves_after_step : assert property
    (
        @(posedge clk) disable iff (reset) !$stable(led) |-> $past(step)
    )
    else
        $error("led changed to %h without a step in the cycle before", led);

endmodule

// File: verification/lab_top_tb.sv
`timescale 1ns/1ps

module lab_top_tb;

    //--------------------------------------------------
    // Timing and sizes
    //--------------------------------------------------

    localparam int clk_period_ns  = 100;
    localparam int drive_delay_ns = 10;
    localparam int step_period    = lab_pkg::step_period;
    localparam int depth          = lab_pkg::depth;
    localparam int w_digit        = display_pkg::w_digit;
    localparam int w_led          = display_pkg::w_led;

    // Steps that pass during one full scan of the display
    localparam int scan_steps = w_digit * display_pkg::scan_period / step_period;
    localparam int scan_limit = 2 * w_digit * display_pkg::scan_period;

    // One term per test, in run order
    localparam int total_steps = scan_steps + (1 + depth) + (1 + 4 * scan_steps)
        + 3 * scan_steps + (20 + scan_steps) + (5 + scan_steps);

    localparam int watchdog_ns = 2 * total_steps * step_period * clk_period_ns
        + scan_limit * clk_period_ns;

    // Entry 0 in the lowest nibble
    localparam logic [63:0] pattern_entries = 64'h385f_a901_4ce7_bd62;

    //--------------------------------------------------
    // DUT and clock
    //--------------------------------------------------

    logic                 clk;
    logic                 reset;
    logic                 restart;
    logic [3:0]           key;
    logic [w_led   - 1:0] led;
    logic [7:0]           abcdefgh;
    logic [w_digit - 1:0] digit;

    tb_clock_gen
    #(
        .period_ns      (clk_period_ns),
        .reset_cycles   (4),
        .drive_delay_ns (drive_delay_ns)
    )
    clock_gen_i
    (
        .restart (restart),
        .clk     (clk),
        .reset   (reset)
    );

    lab_top dut_i
    (
        .clk      (clk),
        .reset    (reset),
        .key      (key),
        .led      (led),
        .abcdefgh (abcdefgh),
        .digit    (digit)
    );

    bind lab_top lab_top_assertions assertions_i
    (
        .clk      (clk),
        .reset    (reset),
        .step     (step),
        .led      (led),
        .abcdefgh (abcdefgh),
        .digit    (digit)
    );

    //--------------------------------------------------
    // Reference model
    //--------------------------------------------------

    int               cyc;
    int               error_count;
    int               test_count;
    int               tests_passed;
    integer           seed = 8;

    logic [depth - 1:0] model_valid;
    logic [3:0]         model_data [0:depth - 1];
    int                 model_index;

    // Cycle 0 is the first cycle after reset
    always @(posedge clk)
    begin
        if (reset)
            cyc <= 0;
        else
            cyc <= cyc + 1;
    end

    function automatic logic [3:0] table_entry(input int i);
        return pattern_entries[4 * (i % 16) +: 4];
    endfunction

    // Last cycle of each step window
    always @(posedge clk)
    begin
        if (reset)
        begin
            model_valid <= '0;
            model_index <= 0;
        end
        else if ((cyc % step_period) == step_period - 1)
        begin
            for (int s = depth - 1; s > 0; s--)
            begin
                model_valid[s] <= model_valid[s - 1];
                model_data[s]  <= model_data[s - 1];
            end

            model_valid[0] <= (key != '0);
            model_data[0]  <= table_entry(model_index);

            if (key != '0)
                model_index <= (model_index + 1) % 16;
        end
    end

    // Stage 0 is the leftmost digit
    function automatic logic [w_led - 1:0] model_led();
        logic [w_led - 1:0] result;
        for (int d = 0; d < w_led; d++)
            result[d] = model_valid[depth - 1 - d];
        return result;
    endfunction

    function automatic logic [7:0] model_code(input int d);
        int stage;
        stage = depth - 1 - d;
        if (model_valid[stage])
            return display_pkg::segment_codes[model_data[stage]];
        else
            return display_pkg::sign_empty_entry;
    endfunction

    //--------------------------------------------------
    // Compare tasks
    //--------------------------------------------------

    task automatic check_led(input logic [w_led - 1:0] expected,
                             input logic [w_led - 1:0] actual);
        if (actual !== expected)
        begin
            $display("** Error: led expected %h, got %h at %0t", expected, actual, $time);
            error_count++;
        end
    endtask

    task automatic check_segments(input logic [7:0] expected, input logic [7:0] actual,
                                  input int digit_index);
        if (actual !== expected)
        begin
            $display("** Error: abcdefgh on digit %0d expected %h, got %h at %0t",
                     digit_index, expected, actual, $time);
            error_count++;
        end
    endtask

    //--------------------------------------------------
    // Stimulus helpers
    //--------------------------------------------------

    task automatic restart_dut;
        key     = '0;
        restart = 1'b1;
        @(negedge reset);
        restart = 1'b0;
    endtask

    // Holds one key value across a whole step window
    task automatic run_step(input logic [3:0] k);
        while ((cyc % step_period) != 0)
        begin
            @(posedge clk);
            #(drive_delay_ns);
        end

        key = k;

        repeat (step_period)
        begin
            @(posedge clk);
            #(drive_delay_ns);
        end
    endtask

    task automatic watch_scan;
        logic [w_digit - 1:0] seen;
        int                   cycles;
        int                   ones;
        int                   d;

        seen   = '0;
        cycles = 0;

        while (seen != '1 && cycles < scan_limit)
        begin
            @(negedge clk);
            cycles++;

            // Segments lag the register by one cycle after a shift
            if ((cyc % step_period) != 0)
            begin
                ones = 0;
                d    = 0;

                for (int i = 0; i < w_digit; i++)
                begin
                    if (digit[i])
                    begin
                        ones++;
                        d = i;
                    end
                end

                if (ones != 1)
                begin
                    $display("Digit select %b is not one-hot at %0t", digit, $time);
                    error_count++;
                end
                else
                begin
                    check_segments(model_code(d), abcdefgh, d);
                    seen[d] = 1'b1;
                end
            end
        end

        if (seen != '1)
        begin
            $display("Scan reached only digits %b within %0d cycles", seen, scan_limit);
            error_count++;
        end
    endtask

    // Nibble i of the sequence is the key value of step i
    task automatic scan_during_steps(input logic [4 * scan_steps - 1:0] key_seq);
        fork
            watch_scan;

            begin
                for (int i = 0; i < scan_steps; i++)
                begin
                    run_step(key_seq[4 * i +: 4]);
                    check_led(model_led(), led);
                end
            end
        join
    endtask

    task automatic random_keys(output logic [4 * scan_steps - 1:0] key_seq);
        int r;

        for (int i = 0; i < scan_steps; i++)
        begin
            r = $random(seed);
            key_seq[4 * i +: 4] = r[0] ? r[7:4] : 4'b0000;
        end
    endtask

    task automatic end_test(input string name, input int errors_at_start);
        test_count++;

        if (error_count == errors_at_start)
        begin
            tests_passed++;
            $display("%s: ok", name);
        end
        else
            $display("%s: %0d errors", name, error_count - errors_at_start);
    endtask

    //--------------------------------------------------
    // Tests
    //--------------------------------------------------

    task automatic reset_state;
        int errors_at_start;

        errors_at_start = error_count;
        check_led('0, led);
        scan_during_steps('0);
        end_test("reset state", errors_at_start);
    endtask

    task automatic single_press_travels;
        int                 errors_at_start;
        logic [w_led - 1:0] expected;

        errors_at_start = error_count;
        restart_dut;

        expected            = '0;
        expected[w_led - 1] = 1'b1;

        run_step(4'b0100);
        check_led(expected, led);

        fork
            watch_scan;

            begin
                for (int j = 0; j < depth; j++)
                begin
                    run_step('0);
                    expected = expected >> 1;
                    check_led(expected, led);
                end
            end
        join

        end_test("single press travels", errors_at_start);
    endtask

    task automatic fill_register;
        int errors_at_start;

        errors_at_start = error_count;

        // Scan and steps share one phase, so every second entry is shown
        restart_dut;
        scan_during_steps({scan_steps{4'b0010}});
        check_led('1, led);
        scan_during_steps({scan_steps{4'b0010}});

        // A leading bubble brings the other half of the entries into view
        restart_dut;
        run_step('0);
        scan_during_steps({scan_steps{4'b0010}});
        check_led('1, led);
        scan_during_steps({scan_steps{4'b0010}});

        end_test("fill register", errors_at_start);
    endtask

    task automatic bubbles_hold_index;
        int                          errors_at_start;
        logic [4 * scan_steps - 1:0] key_seq;

        errors_at_start = error_count;

        repeat (3)
        begin
            random_keys(key_seq);
            scan_during_steps(key_seq);
        end

        end_test("bubbles hold index", errors_at_start);
    endtask

    task automatic index_wraps;
        int errors_at_start;

        errors_at_start = error_count;
        restart_dut;

        // Twenty entries push the index past 15
        repeat (20)
            run_step(4'b1000);

        check_led('1, led);
        scan_during_steps({scan_steps{4'b1000}});
        end_test("index wraps", errors_at_start);
    endtask

    task automatic any_key_counts;
        int                 errors_at_start;
        logic [w_led - 1:0] expected;
        logic [w_led - 1:0] newest;

        errors_at_start = error_count;
        restart_dut;

        expected          = '0;
        newest            = '0;
        newest[w_led - 1] = 1'b1;

        for (int b = 0; b < 4; b++)
        begin
            run_step(4'b0001 << b);
            expected = (expected >> 1) | newest;
            check_led(expected, led);
        end

        run_step('0);
        expected = expected >> 1;
        check_led(expected, led);

        scan_during_steps(32'h1020_4080);
        end_test("any key counts", errors_at_start);
    endtask

    //--------------------------------------------------
    // Main sequence and watchdog
    //--------------------------------------------------

    initial
    begin
        key          = '0;
        restart      = 1'b0;
        error_count  = 0;
        test_count   = 0;
        tests_passed = 0;

        @(negedge reset);

        reset_state;
        single_press_travels;
        fill_register;
        bubbles_hold_index;
        index_wraps;
        any_key_counts;

        $display("Tests: %0d run, %0d passed, %0d errors",
                 test_count, tests_passed, error_count);

        if (error_count == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");

        $finish;
    end

    initial
    begin
        #(watchdog_ns);
        $display("Watchdog expired after %0d ns before the tests finished", watchdog_ns);
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: compile.f
logic/display_pkg.sv
logic/lab_pkg.sv
logic/pattern_source.sv
logic/shift_register_with_valid_and_debug.sv
logic/seven_segment_display.sv
logic/lab_top.sv
verification/tb_clock_gen.sv
verification/lab_top_assertions.sv
verification/lab_top_tb.sv
